// File: tb.f
cmix_pkg.sv
cmix_stream_if.sv
real_mult.sv
complex_mult.sv
sample_fifo.sv
round_sat.sv
cmix_regs.sv
cmix_top.sv
tb_cmix.sv

// File: Bender.yml
package:
  name: cmix

sources:
  - cmix_pkg.sv
  - cmix_stream_if.sv
  - real_mult.sv
  - complex_mult.sv
  - sample_fifo.sv
  - round_sat.sv
  - cmix_regs.sv
  - cmix_top.sv
  - target: test
    files:
      - tb_cmix.sv

// File: tb_cmix.sv
`timescale 1ns/1ns

module tb_cmix;

    localparam int wait_limit = 200;
    localparam longint out_max = (longint'(1) <<< (cmix_pkg::sample_w - 1)) - 1;
    localparam longint out_min = -(longint'(1) <<< (cmix_pkg::sample_w - 1));

    logic                                 clk;
    logic                                 rst;
    logic signed [cmix_pkg::sample_w-1:0] in_re;
    logic signed [cmix_pkg::sample_w-1:0] in_im;
    logic                                 in_valid;
    logic                                 in_ready;
    logic signed [cmix_pkg::sample_w-1:0] out_re;
    logic signed [cmix_pkg::sample_w-1:0] out_im;
    logic                                 out_valid;
    logic                                 out_ready;
    logic [cmix_pkg::axi_addr_w-1:0]      awaddr;
    logic                                 awvalid;
    logic                                 awready;
    logic [31:0]                          wdata;
    logic                                 wvalid;
    logic                                 wready;
    logic [1:0]                           bresp;
    logic                                 bvalid;
    logic                                 bready;
    logic [cmix_pkg::axi_addr_w-1:0]      araddr;
    logic                                 arvalid;
    logic                                 arready;
    logic [31:0]                          rdata;
    logic [1:0]                           rresp;
    logic                                 rvalid;
    logic                                 rready;

    logic [31:0] lfsr_state;
    logic [31:0] expected [$];
    logic [15:0] model_coef_re;
    logic [15:0] model_coef_im;
    int          model_shift;
    int          sat_expected;
    int          errors;
    int          checks;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    string       test_name;

    cmix_top UUT (
        .clk(clk), .rst(rst),
        .in_re(in_re), .in_im(in_im), .in_valid(in_valid), .in_ready(in_ready),
        .out_re(out_re), .out_im(out_im), .out_valid(out_valid), .out_ready(out_ready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    always #4 clk = ~clk;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // add half an lsb of the result when shifting, then arithmetic shift
    function automatic longint round_half_up(input longint p, input int sh);
        longint half;
        half = (sh > 0) ? (longint'(1) <<< (sh - 1)) : 0;
        return (p + half) >>> sh;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("error %s: got %h, expected %h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("%s", what);
        errors++;
        test_errors++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", tests_run, test_name,
                 (test_errors == 0) ? "passed" : "failed");
    endtask

    // reference model for one accepted sample
    task automatic expect_sample(input logic [15:0] re, input logic [15:0] im);
        longint      xr;
        longint      xi;
        longint      cr;
        longint      ci;
        longint      v [2];
        logic [15:0] y [2];
        bit          clip;
        xr = longint'($signed(re));
        xi = longint'($signed(im));
        cr = longint'($signed(model_coef_re));
        ci = longint'($signed(model_coef_im));
        v[0] = round_half_up(cr * xr - ci * xi, model_shift);
        v[1] = round_half_up(ci * xr + cr * xi, model_shift);
        clip = 1'b0;
        for (int k = 0; k < 2; k++) begin
            if (v[k] > out_max) begin
                y[k] = 16'h7fff;
                clip = 1'b1;
            end else if (v[k] < out_min) begin
                y[k] = 16'h8000;
                clip = 1'b1;
            end else begin
                y[k] = 16'(v[k]);
            end
        end
        if (clip) begin
            sat_expected++;
        end
        expected.push_back({y[1], y[0]});
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int waited;
        waited = 0;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        // address and data are taken together as soon as both are valid
        #1;
        check_value("awready", awready, 1'b1);
        check_value("wready", wready, 1'b1);
        @(negedge clk);
        while (!bvalid && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        resp    = bresp;
        if (!bvalid) begin
            note_failure("timeout: write response never came");
        end else if (addr == cmix_pkg::addr_coef) begin
            model_coef_re = data[15:0];
            model_coef_im = data[31:16];
        end else if (addr == cmix_pkg::addr_shift) begin
            model_shift = data[4:0];
        end
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int waited;
        waited = 0;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        // no read is outstanding here
        check_value("arready", arready, 1'b1);
        @(negedge clk);
        while (!rvalid && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        arvalid = 1'b0;
        data    = rdata;
        resp    = rresp;
        if (!rvalid) begin
            note_failure("timeout: read data never came");
        end
    endtask

    // in_ready only moves on a rising edge, so a drive seen ready is taken at the next one
    task automatic send_sample(input logic [15:0] re, input logic [15:0] im);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!in_ready && waited < wait_limit) begin
            in_valid = 1'b0;
            @(negedge clk);
            waited++;
        end
        if (!in_ready) begin
            in_valid = 1'b0;
            note_failure("timeout: input never became ready");
        end else begin
            in_re    = re;
            in_im    = im;
            in_valid = 1'b1;
            expect_sample(re, im);
        end
    endtask

    task automatic end_input();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // ready is driven here, so a valid seen at this edge transfers at the next rising one
    task automatic recv_sample();
        int          waited;
        logic [31:0] exp;
        waited = 0;
        @(negedge clk);
        out_ready = 1'b1;
        while (!out_valid && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!out_valid) begin
            note_failure("timeout: no output sample arrived");
        end else if (expected.size() == 0) begin
            note_failure("output sample arrived with none expected");
        end else begin
            exp = expected.pop_front();
            check_value("out_re", $unsigned(out_re), {16'h0, exp[15:0]});
            check_value("out_im", $unsigned(out_im), {16'h0, exp[31:16]});
        end
    endtask

    task automatic check_reset_values();
        logic [31:0] data;
        logic [1:0]  resp;
        start_test("reset values");
        axi_read(cmix_pkg::addr_coef, data, resp);
        check_value("rdata", data, 32'h0000_7fff);
        check_value("rresp", resp, 2'b00);
        axi_read(cmix_pkg::addr_shift, data, resp);
        check_value("rdata", data, 32'd15);
        axi_read(cmix_pkg::addr_status, data, resp);
        check_value("rdata", data, 32'd0);
        send_sample(16'h1234, 16'hedcc);
        end_input();
        recv_sample();
        finish_test();
    endtask

    task automatic run_single_product();
        logic [1:0] resp;
        start_test("single product");
        axi_write(cmix_pkg::addr_coef, 32'he000_4000, resp);
        check_value("bresp", resp, 2'b00);
        axi_write(cmix_pkg::addr_shift, 32'd14, resp);
        send_sample(16'd3000, 16'hfb2e);
        end_input();
        recv_sample();
        finish_test();
    endtask

    task automatic run_random_stream();
        logic [1:0] resp;
        start_test("random stream");
        axi_write(cmix_pkg::addr_coef, 32'ha57e_5a82, resp);
        axi_write(cmix_pkg::addr_shift, 32'd15, resp);
        fork
            begin
                for (int i = 0; i < 64; i++) begin
                    send_sample(16'(rand_bits(16)), 16'(rand_bits(16)));
                end
                end_input();
            end
            begin
                for (int i = 0; i < 64; i++) begin
                    recv_sample();
                end
            end
        join
        check_value("pending samples", expected.size(), 0);
        finish_test();
    endtask

    task automatic run_back_pressure();
        int accepted;
        bit fell;
        start_test("back-pressure");
        accepted = 0;
        fell = 1'b0;
        @(negedge clk);
        out_ready = 1'b0;
        for (int i = 0; i < cmix_pkg::fifo_depth + 8 && !fell; i++) begin
            @(negedge clk);
            if (in_ready) begin
                in_re    = 16'(rand_bits(16));
                in_im    = 16'(rand_bits(16));
                in_valid = 1'b1;
                expect_sample(in_re, in_im);
                accepted++;
            end else begin
                in_valid = 1'b0;
                fell = 1'b1;
            end
        end
        if (!fell) begin
            end_input();
            note_failure("input ready stayed high while the output was stalled");
        end
        // the output register holds one sample beyond the fifo
        if (accepted > cmix_pkg::fifo_depth + 1) begin
            note_failure("input ready fell too late to protect the fifo");
        end
        // the receiver lifts the stall on its first edge
        repeat (8) @(negedge clk);
        for (int i = 0; i < accepted; i++) begin
            recv_sample();
        end
        check_value("pending samples", expected.size(), 0);
        finish_test();
    endtask

    task automatic run_saturation();
        logic [31:0] data;
        logic [1:0]  resp;
        logic [15:0] s_re [5] = '{16'h1000, 16'h8000, 16'h0000, 16'h0001, 16'h7fff};
        logic [15:0] s_im [5] = '{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h7fff};
        start_test("saturation");
        axi_write(cmix_pkg::addr_coef, 32'h7fff_7fff, resp);
        axi_write(cmix_pkg::addr_shift, 32'd0, resp);
        axi_write(cmix_pkg::addr_status, 32'd0, resp);
        sat_expected = 0;
        fork
            begin
                for (int i = 0; i < 5; i++) begin
                    send_sample(s_re[i], s_im[i]);
                end
                end_input();
            end
            begin
                for (int i = 0; i < 5; i++) begin
                    recv_sample();
                end
            end
        join
        axi_read(cmix_pkg::addr_status, data, resp);
        check_value("rdata", data, sat_expected);
        axi_write(cmix_pkg::addr_status, 32'h0000_0001, resp);
        check_value("bresp", resp, 2'b00);
        axi_read(cmix_pkg::addr_status, data, resp);
        check_value("rdata", data, 32'd0);
        finish_test();
    endtask

    task automatic check_bad_address();
        logic [31:0] data;
        logic [1:0]  resp;
        start_test("bad address");
        axi_write(4'hc, 32'h1234_5678, resp);
        check_value("bresp", resp, 2'b10);
        axi_read(4'hc, data, resp);
        check_value("rresp", resp, 2'b10);
        check_value("rdata", data, 32'd0);
        axi_read(cmix_pkg::addr_coef, data, resp);
        check_value("rdata", data, {model_coef_im, model_coef_re});
        axi_read(cmix_pkg::addr_shift, data, resp);
        check_value("rdata", data, model_shift);
        finish_test();
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        in_re = '0;
        in_im = '0;
        in_valid = 1'b0;
        out_ready = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        lfsr_state = 32'hf7574813;
        // register values after reset
        model_coef_re = 16'h7fff;
        model_coef_im = 16'h0000;
        model_shift = 15;
        sat_expected = 0;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_reset_values();
        run_single_product();
        run_random_stream();
        run_back_pressure();
        run_saturation();
        check_bad_address();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: cmix_top.sv
`timescale 1ns/1ns

module cmix_top (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic signed [cmix_pkg::sample_w-1:0]  in_re,
    input  logic signed [cmix_pkg::sample_w-1:0]  in_im,
    input  logic                                  in_valid,
    output logic                                  in_ready,
    output logic signed [cmix_pkg::sample_w-1:0]  out_re,
    output logic signed [cmix_pkg::sample_w-1:0]  out_im,
    output logic                                  out_valid,
    input  logic                                  out_ready,
    input  logic [cmix_pkg::axi_addr_w-1:0]       awaddr,
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [cmix_pkg::axi_data_w-1:0]       wdata,
    input  logic                                  wvalid,
    output logic                                  wready,
    output logic [1:0]                            bresp,
    output logic                                  bvalid,
    input  logic                                  bready,
    input  logic [cmix_pkg::axi_addr_w-1:0]       araddr,
    input  logic                                  arvalid,
    output logic                                  arready,
    output logic [cmix_pkg::axi_data_w-1:0]       rdata,
    output logic [1:0]                            rresp,
    output logic                                  rvalid,
    input  logic                                  rready
);

    logic signed [cmix_pkg::coef_w-1:0] coef_re;
    logic signed [cmix_pkg::coef_w-1:0] coef_im;
    logic [cmix_pkg::shift_w-1:0]       shift;
    logic [cmix_pkg::sat_cnt_w-1:0]     sat_count;
    logic                               sat_clear;

    cmix_stream_if prod_s ();
    cmix_stream_if fifo_s ();

    cmix_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .coef_re   (coef_re),
        .coef_im   (coef_im),
        .shift     (shift),
        .sat_count (sat_count),
        .sat_clear (sat_clear)
    );

    complex_mult u_mult (
        .clk      (clk),
        .rst      (rst),
        .in_re    (in_re),
        .in_im    (in_im),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .coef_re  (coef_re),
        .coef_im  (coef_im),
        .prod     (prod_s.src)
    );

    // fifo credit is the input ready
    sample_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr        (prod_s.dst),
        .rd        (fifo_s.src),
        .credit_ok (in_ready)
    );

    round_sat u_round (
        .clk       (clk),
        .rst       (rst),
        .in        (fifo_s.dst),
        .shift     (shift),
        .out_re    (out_re),
        .out_im    (out_im),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .sat_clear (sat_clear),
        .sat_count (sat_count)
    );

endmodule

// File: cmix_regs.sv
`timescale 1ns/1ns

module cmix_regs (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [cmix_pkg::axi_addr_w-1:0]       awaddr,
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [cmix_pkg::axi_data_w-1:0]       wdata,
    input  logic                                  wvalid,
    output logic                                  wready,
    output logic [1:0]                            bresp,
    output logic                                  bvalid,
    input  logic                                  bready,
    input  logic [cmix_pkg::axi_addr_w-1:0]       araddr,
    input  logic                                  arvalid,
    output logic                                  arready,
    output logic [cmix_pkg::axi_data_w-1:0]       rdata,
    output logic [1:0]                            rresp,
    output logic                                  rvalid,
    input  logic                                  rready,
    output logic signed [cmix_pkg::coef_w-1:0]    coef_re,
    output logic signed [cmix_pkg::coef_w-1:0]    coef_im,
    output logic [cmix_pkg::shift_w-1:0]          shift,
    input  logic [cmix_pkg::sat_cnt_w-1:0]        sat_count,
    output logic                                  sat_clear
);

    logic wr_fire;
    logic rd_fire;

    function automatic logic addr_ok(input logic [cmix_pkg::axi_addr_w-1:0] addr);
        return addr == cmix_pkg::addr_coef || addr == cmix_pkg::addr_shift ||
               addr == cmix_pkg::addr_status;
    endfunction

    // aw and w taken together, one write outstanding
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;

    assign arready = !rvalid;
    assign rd_fire = arvalid && arready;

    always_ff @(posedge clk) begin
        if (rst) begin
            coef_re   <= cmix_pkg::coef_re_init;
            coef_im   <= '0;
            shift     <= cmix_pkg::shift_init;
            sat_clear <= 1'b0;
            bvalid    <= 1'b0;
            bresp     <= cmix_pkg::resp_okay;
        end else begin
            sat_clear <= wr_fire && awaddr == cmix_pkg::addr_status;
            if (wr_fire) begin
                bvalid <= 1'b1;
                bresp  <= addr_ok(awaddr) ? cmix_pkg::resp_okay : cmix_pkg::resp_slverr;
                if (awaddr == cmix_pkg::addr_coef) begin
                    coef_re <= wdata[cmix_pkg::coef_w-1:0];
                    coef_im <= wdata[2*cmix_pkg::coef_w-1:cmix_pkg::coef_w];
                end
                if (awaddr == cmix_pkg::addr_shift) begin
                    shift <= wdata[cmix_pkg::shift_w-1:0];
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
            rdata  <= '0;
            rresp  <= cmix_pkg::resp_okay;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
            rresp  <= addr_ok(araddr) ? cmix_pkg::resp_okay : cmix_pkg::resp_slverr;
            case (araddr)
                cmix_pkg::addr_coef:   rdata <= {coef_im, coef_re};
                cmix_pkg::addr_shift:  rdata <= {{(cmix_pkg::axi_data_w-cmix_pkg::shift_w){1'b0}},
                                                 shift};
                cmix_pkg::addr_status: rdata <= {{(cmix_pkg::axi_data_w-cmix_pkg::sat_cnt_w){1'b0}},
                                                 sat_count};
                default:               rdata <= '0;
            endcase
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    a_b_hold: assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid);

endmodule

// File: round_sat.sv
`timescale 1ns/1ns

module round_sat (
    input  logic                                  clk,
    input  logic                                  rst,
    cmix_stream_if.dst                            in,
    input  logic [cmix_pkg::shift_w-1:0]          shift,
    output logic signed [cmix_pkg::sample_w-1:0]  out_re,
    output logic signed [cmix_pkg::sample_w-1:0]  out_im,
    output logic                                  out_valid,
    input  logic                                  out_ready,
    input  logic                                  sat_clear,
    output logic [cmix_pkg::sat_cnt_w-1:0]        sat_count
);

    logic signed [cmix_pkg::prod_w:0] sh_re;
    logic signed [cmix_pkg::prod_w:0] sh_im;
    logic                             clip_re;
    logic                             clip_im;
    logic                             take;

    // add half an lsb of the result, then arithmetic shift
    function automatic logic signed [cmix_pkg::prod_w:0] round_shift(
        input logic signed [cmix_pkg::prod_w-1:0] x,
        input logic [cmix_pkg::shift_w-1:0]       sh
    );
        logic signed [cmix_pkg::prod_w:0] half;
        logic signed [cmix_pkg::prod_w:0] sum;
        half = (sh == '0) ? '0 : ({{cmix_pkg::prod_w{1'b0}}, 1'b1} << (sh - 1'b1));
        sum  = x + half;
        return sum >>> sh;
    endfunction

    // fits only if all bits above the output sign agree with it
    function automatic logic clips(input logic signed [cmix_pkg::prod_w:0] v);
        return !(&v[cmix_pkg::prod_w:cmix_pkg::sample_w-1] ||
                 ~|v[cmix_pkg::prod_w:cmix_pkg::sample_w-1]);
    endfunction

    function automatic logic signed [cmix_pkg::sample_w-1:0] clamp(
        input logic signed [cmix_pkg::prod_w:0] v
    );
        if (!clips(v)) begin
            return v[cmix_pkg::sample_w-1:0];
        end
        return v[cmix_pkg::prod_w] ? {1'b1, {(cmix_pkg::sample_w-1){1'b0}}}
                                   : {1'b0, {(cmix_pkg::sample_w-1){1'b1}}};
    endfunction

    assign sh_re   = round_shift(in.re, shift);
    assign sh_im   = round_shift(in.im, shift);
    assign clip_re = clips(sh_re);
    assign clip_im = clips(sh_im);

    // output register empty or being drained
    assign in.ready = !out_valid || out_ready;
    assign take     = in.valid && in.ready;

    always_ff @(posedge clk) begin
        if (take) begin
            out_re <= clamp(sh_re);
            out_im <= clamp(sh_im);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            sat_count <= '0;
        end else begin
            if (take) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
            // clear wins over a same-cycle clip, count sticks at max
            if (sat_clear) begin
                sat_count <= '0;
            end else if (take && (clip_re || clip_im) && sat_count != '1) begin
                sat_count <= sat_count + 1'b1;
            end
        end
    end

endmodule

// File: sample_fifo.sv
`timescale 1ns/1ns

module sample_fifo (
    input  logic        clk,
    input  logic        rst,
    cmix_stream_if.dst  wr,
    cmix_stream_if.src  rd,
    output logic        credit_ok
);

    logic signed [cmix_pkg::prod_w-1:0] mem_re [cmix_pkg::fifo_depth];
    logic signed [cmix_pkg::prod_w-1:0] mem_im [cmix_pkg::fifo_depth];
    logic [cmix_pkg::fifo_ptr_w-1:0]    wr_ptr;
    logic [cmix_pkg::fifo_ptr_w-1:0]    rd_ptr;
    logic [cmix_pkg::fifo_ptr_w:0]      count;
    logic                               full;
    logic                               push;
    logic                               pop;

    assign full     = (count == cmix_pkg::fifo_depth);
    assign wr.ready = !full;
    // producer cannot stall, push on every valid
    assign push     = wr.valid;
    assign pop      = rd.valid && rd.ready;

    // leave room for everything still in the multiplier pipe
    assign credit_ok = (count <= cmix_pkg::fifo_depth - cmix_pkg::mult_latency - 1);

    always_ff @(posedge clk) begin
        if (push) begin
            mem_re[wr_ptr] <= wr.re;
            mem_im[wr_ptr] <= wr.im;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign rd.valid = (count != '0);
    assign rd.re    = mem_re[rd_ptr];
    assign rd.im    = mem_im[rd_ptr];

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(wr.valid && full));

endmodule

// File: complex_mult.sv
`timescale 1ns/1ns

module complex_mult (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic signed [cmix_pkg::sample_w-1:0]  in_re,
    input  logic signed [cmix_pkg::sample_w-1:0]  in_im,
    input  logic                                  in_valid,
    input  logic                                  in_ready,
    input  logic signed [cmix_pkg::coef_w-1:0]    coef_re,
    input  logic signed [cmix_pkg::coef_w-1:0]    coef_im,
    cmix_stream_if.src                            prod
);

    logic                                 in_fire;
    logic                                 x_vld;
    logic signed [cmix_pkg::sample_w-1:0] x_re_q;
    logic signed [cmix_pkg::sample_w-1:0] x_im_q;
    logic signed [cmix_pkg::coef_w-1:0]   c_re_q;
    logic signed [cmix_pkg::coef_w-1:0]   c_im_q;

    logic signed [cmix_pkg::coef_w-1:0]                     mul_a [4];
    logic signed [cmix_pkg::sample_w-1:0]                   mul_b [4];
    logic signed [cmix_pkg::coef_w+cmix_pkg::sample_w-1:0]  mul_p [4];
    logic [3:0]                                             mul_vld;

    assign in_fire = in_valid && in_ready;

    // coefficient captured with the sample so a register write never splits a product
    always_ff @(posedge clk) begin
        if (in_fire) begin
            x_re_q <= in_re;
            x_im_q <= in_im;
            c_re_q <= coef_re;
            c_im_q <= coef_im;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            x_vld <= 1'b0;
        end else begin
            x_vld <= in_fire;
        end
    end

    // products in order rr, ri, ir, ii
    assign mul_a[0] = c_re_q;
    assign mul_b[0] = x_re_q;
    assign mul_a[1] = c_im_q;
    assign mul_b[1] = x_re_q;
    assign mul_a[2] = c_re_q;
    assign mul_b[2] = x_im_q;
    assign mul_a[3] = c_im_q;
    assign mul_b[3] = x_im_q;

    for (genvar i = 0; i < 4; i++) begin : g_mult
        real_mult u_mult (
            .clk       (clk),
            .rst       (rst),
            .a         (mul_a[i]),
            .b         (mul_b[i]),
            .in_valid  (x_vld),
            .p         (mul_p[i]),
            .out_valid (mul_vld[i])
        );
    end

    // re = rr - ii, im = ri + ir
    always_ff @(posedge clk) begin
        if (mul_vld[0]) begin
            prod.re <= mul_p[0] - mul_p[3];
            prod.im <= mul_p[1] + mul_p[2];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prod.valid <= 1'b0;
        end else begin
            prod.valid <= mul_vld[0];
        end
    end

    a_mult_lockstep: assert property (@(posedge clk) disable iff (rst)
        mul_vld == 4'b0000 || mul_vld == 4'b1111);

endmodule

// File: real_mult.sv
`timescale 1ns/1ns

module real_mult (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  logic signed [cmix_pkg::coef_w-1:0]                     a,
    input  logic signed [cmix_pkg::sample_w-1:0]                   b,
    input  logic                                                   in_valid,
    output logic signed [cmix_pkg::coef_w+cmix_pkg::sample_w-1:0]  p,
    output logic                                                   out_valid
);

    logic signed [cmix_pkg::coef_w-1:0]   a_q;
    logic signed [cmix_pkg::sample_w-1:0] b_q;
    logic [cmix_pkg::mult_stages-1:0]     vld_pipe;

    // operand regs then product reg, fits the dsp slice pipeline
    always_ff @(posedge clk) begin
        a_q <= a;
        b_q <= b;
        p   <= a_q * b_q;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[cmix_pkg::mult_stages-2:0], in_valid};
        end
    end

    assign out_valid = vld_pipe[cmix_pkg::mult_stages-1];

    a_valid_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(out_valid));

endmodule

// File: cmix_stream_if.sv
`timescale 1ns/1ns

interface cmix_stream_if;

    logic signed [cmix_pkg::prod_w-1:0] re;
    logic signed [cmix_pkg::prod_w-1:0] im;
    logic                               valid;
    logic                               ready;

    modport src (
        output re, im, valid,
        input  ready
    );

    modport dst (
        input  re, im, valid,
        output ready
    );

endinterface

// File: cmix_pkg.sv
package cmix_pkg;

    // sample and coefficient widths
    localparam int sample_w = 16;
    localparam int coef_w   = 16;
    // full complex product component, one guard bit for the add stage
    localparam int prod_w   = sample_w + coef_w + 1;

    localparam int mult_stages  = 2;
    // input register, multiplier stages, add stage
    localparam int mult_latency = mult_stages + 2;

    localparam int fifo_depth = 16;
    localparam int fifo_ptr_w = $clog2(fifo_depth);

    localparam int shift_w   = 5;
    localparam int sat_cnt_w = 16;

    // axi4-lite register map
    localparam int axi_addr_w = 4;
    localparam int axi_data_w = 32;
    localparam logic [axi_addr_w-1:0] addr_coef   = 4'h0;
    localparam logic [axi_addr_w-1:0] addr_shift  = 4'h4;
    localparam logic [axi_addr_w-1:0] addr_status = 4'h8;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // unity gain in q15, output shift to match
    localparam logic [coef_w-1:0]  coef_re_init = 16'h7fff;
    localparam logic [shift_w-1:0] shift_init   = 5'd15;

endpackage
